// ==== Bender.yml ====
package:
  name: cartridge

sources:
  - cart_pkg.sv
  - cart_map_if.sv
  - cart_bank_table.sv
  - cart_mapper.sv
  - cart_addr_xlate.sv
  - cartridge.sv
  - target: simulation
    files:
      - cart_asserts.sv
      - cart_monitor.sv
      - tb_cartridge.sv

// ==== cart_addr_xlate.sv ====
// CPU to SDRAM address translation
`timescale 1ns/1ps

module cart_addr_xlate
	import cart_pkg::*;
(
	input  logic                  reset_n,
	input  logic                  romL,
	input  logic                  romH,
	input  logic                  IOE,
	input  logic                  IOF,
	input  logic                  mem_write,
	input  logic                  mem_ce,
	input  logic [15:0]           addr_in,
	cart_map_if.xlate             map,
	output logic [ADDR_OUT_W-1:0] addr_out,
	output logic                  mem_write_out,
	output logic                  mem_ce_out,
	output logic                  exrom,
	output logic                  game
);

	logic cs_ioe;
	logic cs_iof;
	logic ultimax;

	// SDRAM bank prefix for address bits 20:13
	function automatic logic [7:0] get_bank(input logic [BANK_W-1:0] bank, input logic ram);
		if (ram)
			return RAM_BASE_BANK | {5'b00000, bank[2:0]};
		else
			return ROM_BASE_BANK | {1'b0, bank};
	endfunction

	assign exrom   = map.exrom_ovr;
	assign game    = map.game_ovr;
	assign ultimax = map.exrom_ovr && !map.game_ovr;

	// IOE is a read only window, IOF may hold RAM
	assign cs_ioe = IOE && map.ioe_ena && !mem_write;
	assign cs_iof = IOF && (mem_write ? map.iof_wr_ena : map.iof_ena);

	assign mem_ce_out = mem_ce || (cs_ioe && map.stb_ioe) || (cs_iof && map.stb_iof);

	// No RAM below ROML in Ultimax mode
	assign mem_write_out = mem_write && !(romL && ultimax);

	always_comb begin
		addr_out = {{(ADDR_OUT_W-16){1'b0}}, addr_in};

		if (!reset_n) begin
			if (romH && !mem_write)
				addr_out[ADDR_OUT_W-1:PAGE_W] = {2'b00, get_bank(map.bank_hi, 1'b0)};
			if (romL && !mem_write)
				addr_out = {2'b00, get_bank(map.bank_lo, 1'b0), addr_in[PAGE_W-1:0]};

			// DExx and DFxx pages of the selected bank
			if (cs_ioe)
				addr_out[ADDR_OUT_W-1:PAGE_W] = {2'b00, get_bank(map.bank_lo, 1'b0)};
			if (cs_iof)
				addr_out[ADDR_OUT_W-1:PAGE_W] = {2'b00, get_bank(map.iof_bank, map.iof_wr_ena)};
		end
	end

endmodule

// ==== cart_asserts.sv ====
// Cartridge top level assertions
`timescale 1ns/1ps

module cart_asserts
	import cart_pkg::*;
(
	input logic        clk32,
	input logic        reset_n,
	input logic [15:0] cart_id,
	input logic        ioe,
	input logic        iof,
	input logic        roml,
	input logic        exrom,
	input logic        mem_ce,
	input logic        mem_ce_out,
	input logic [15:0] addr_in,
	input logic [22:0] addr_out
);

	// Count of failed assertions
	int assert_errs = 0;

	// Extra memory enables only in the first cycle of an IO window
	ce_pulse: assert property (@(posedge clk32) disable iff (reset_n)
		mem_ce_out != mem_ce |-> !mem_ce && ($rose(ioe) || $rose(iof)))
		else begin
			$error("mem_ce_out differs from mem_ce outside an IO window edge");
			assert_errs++;
		end

	// No translation while the mapper is held in reset
	addr_pass: assert property (@(posedge clk32) reset_n |-> addr_out == {7'd0, addr_in})
		else begin
			$error("addr_out translated during reset");
			assert_errs++;
		end

	// Epyx ROML or IOE access pulls EXROM low on the next cycle
	epyx_low: assert property (@(posedge clk32) disable iff (reset_n)
		cart_id == CART_EPYX && $stable(cart_id) && (ioe || roml) |=> !exrom)
		else begin
			$error("exrom not low after an Epyx access");
			assert_errs++;
		end

endmodule

bind cartridge cart_asserts u_asserts (
	.clk32      (clk32),
	.reset_n    (reset_n),
	.cart_id    (cart_id),
	.ioe        (IOE),
	.iof        (IOF),
	.roml       (romL),
	.exrom      (exrom),
	.mem_ce     (mem_ce),
	.mem_ce_out (mem_ce_out),
	.addr_in    (addr_in),
	.addr_out   (addr_out)
);

// ==== cart_bank_table.sv ====
// CRT bank table
`timescale 1ns/1ps

module cart_bank_table
	import cart_pkg::*;
(
	input  logic              clk32,
	input  logic              cart_loading,
	input  logic              cart_bank_wr,
	input  logic [15:0]       cart_bank_num,
	input  logic [15:0]       cart_bank_laddr,
	input  logic [15:0]       cart_bank_size,
	input  logic [22:0]       cart_bank_raddr,
	input  logic [SLOT_W-1:0] sel_slot,
	output logic [BANK_W-1:0] lo_bank0,
	output logic [BANK_W-1:0] hi_bank0,
	output logic [BANK_W-1:0] lo_sel,
	output logic [BANK_W-1:0] hi_sel,
	output logic [7:0]        bank_cnt
);

	// SDRAM bank of each chip packet, ROML and ROMH halves
	logic [BANK_W-1:0] lo_banks [BANK_SLOTS];
	logic [BANK_W-1:0] hi_banks [BANK_SLOTS];

	logic              old_loading;
	logic [SLOT_W-1:0] slot;
	logic [BANK_W-1:0] sdram_bank;

	assign slot       = cart_bank_num[SLOT_W-1:0];
	// Packet start address bits 19:13
	assign sdram_bank = cart_bank_raddr[PAGE_W+BANK_W-1:PAGE_W];

	// Packet counter, restarts with each new image
	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;
		if (!old_loading && cart_loading)
			bank_cnt <= '0;
		else if (cart_bank_wr)
			bank_cnt <= bank_cnt + 8'd1;
	end

	// Table fill, packets beyond the table are dropped
	always_ff @(posedge clk32) begin
		if (cart_bank_wr && cart_bank_num < 16'(BANK_SLOTS)) begin
			if (cart_bank_laddr <= 16'h8000) begin
				lo_banks[slot] <= sdram_bank;
				// 16 KB packet covers ROMH with the following bank
				if (cart_bank_size > 16'h2000)
					hi_banks[slot] <= sdram_bank + 1'b1;
			end else begin
				hi_banks[slot] <= sdram_bank;
			end
		end
	end

	assign lo_bank0 = lo_banks[0];
	assign hi_bank0 = hi_banks[0];
	assign lo_sel   = lo_banks[sel_slot];
	assign hi_sel   = hi_banks[sel_slot];

endmodule

// ==== cart_map_if.sv ====
// Mapper state link
`timescale 1ns/1ps

interface cart_map_if
	import cart_pkg::*;
();

	// ROML and ROMH bank numbers
	logic [BANK_W-1:0] bank_lo;
	logic [BANK_W-1:0] bank_hi;

	// Bank seen through the IOF window
	logic [BANK_W-1:0] iof_bank;

	// IO window enables
	logic              ioe_ena;
	logic              iof_ena;
	logic              iof_wr_ena;

	// Cartridge line levels
	logic              exrom_ovr;
	logic              game_ovr;

	// Rising edge strobes of IOE and IOF
	logic              stb_ioe;
	logic              stb_iof;

	modport mapper (
		output bank_lo, bank_hi, iof_bank,
		output ioe_ena, iof_ena, iof_wr_ena,
		output exrom_ovr, game_ovr,
		output stb_ioe, stb_iof
	);

	modport xlate (
		input bank_lo, bank_hi, iof_bank,
		input ioe_ena, iof_ena, iof_wr_ena,
		input exrom_ovr, game_ovr,
		input stb_ioe, stb_iof
	);

endinterface

// ==== cart_mapper.sv ====
// Cartridge bank mapper
`timescale 1ns/1ps

module cart_mapper
	import cart_pkg::*;
(
	input  logic              clk32,
	input  logic              reset_n,
	input  logic [15:0]       cart_id,
	input  logic [7:0]        cart_exrom,
	input  logic [7:0]        cart_game,
	input  logic              cart_bank_wr,
	input  logic [15:0]       cart_bank_num,
	input  logic              IOE,
	input  logic              IOF,
	input  logic              romL,
	input  logic              mem_write,
	input  logic [15:0]       addr_in,
	input  logic [7:0]        data_in,
	input  logic [BANK_W-1:0] lo_bank0,
	input  logic [BANK_W-1:0] hi_bank0,
	input  logic [BANK_W-1:0] lo_sel,
	input  logic [BANK_W-1:0] hi_sel,
	input  logic [7:0]        bank_cnt,
	output logic [SLOT_W-1:0] sel_slot,
	cart_map_if.mapper        map
);

	cart_type_e  cart_type;
	logic [15:0] old_id;
	logic        init_n;
	logic        old_ioe;
	logic        old_iof;
	logic        ioe_wr;
	logic        reg_sel;

	// Epyx discharge timer
	logic [15:0] count;
	logic        count_ena;

	assign cart_type = cart_type_e'(cart_id);

	// **************************************************
	// IO window edges
	// **************************************************

	always_ff @(posedge clk32) begin
		old_ioe <= IOE;
		old_iof <= IOF;
	end

	assign map.stb_ioe = IOE && !old_ioe;
	assign map.stb_iof = IOF && !old_iof;
	assign ioe_wr      = map.stb_ioe && mem_write;

	// EasyFlash: DE02 is the mode register, DE00 the bank register
	assign reg_sel  = |(addr_in[7:0] & IO_REG_ADDR);
	// Bank table lookup follows the written bank number
	assign sel_slot = data_in[SLOT_W-1:0];

	// **************************************************
	// Per type bank and line control
	// **************************************************

	always_ff @(posedge clk32) begin
		init_n <= 1'b1;
		old_id <= cart_id;

		if (reset_n || old_id != cart_id) begin
			map.bank_lo    <= '0;
			map.bank_hi    <= '0;
			map.iof_bank   <= '0;
			map.ioe_ena    <= 1'b0;
			map.iof_ena    <= 1'b0;
			map.iof_wr_ena <= 1'b0;
			map.exrom_ovr  <= 1'b1;
			map.game_ovr   <= 1'b1;
			count          <= '0;
			count_ena      <= 1'b0;
			init_n         <= 1'b0;
		end else begin
			case (cart_type)
				// Ocean type 1, ROML and ROMH mirror the same 8 KB bank
				CART_OCEAN: begin
					if (!init_n) begin
						map.exrom_ovr <= 1'b0;
						map.game_ovr  <= 1'b0;
					end
					if (ioe_wr) begin
						map.bank_lo <= {1'b0, data_in[5:0]};
						map.bank_hi <= {1'b0, data_in[5:0]};
					end
					// Type B images (512 KB) leave A000 to RAM
					if (cart_bank_wr && cart_bank_num >= 16'd32)
						map.game_ovr <= 1'b1;
				end

				// Epyx Fastload, ROML or IOE access recharges the capacitor
				CART_EPYX: begin
					if (!init_n)
						count_ena <= 1'b0;
					if (IOE || romL)
						count_ena <= 1'b1;

					if (!init_n || IOE || romL) begin
						map.exrom_ovr <= 1'b0;
						map.game_ovr  <= 1'b1;
						map.iof_ena   <= 1'b1;
						map.iof_bank  <= '0;
						count         <= EPYX_DISCHARGE;
					end else if (count_ena) begin
						if (count != 16'd0)
							count <= count - 16'd1;
						else
							map.exrom_ovr <= 1'b1;
					end
				end

				// Magic Desk, 8 KB mode, register width from image size
				CART_MAGIC_DESK: begin
					if (!init_n) begin
						map.exrom_ovr <= 1'b0;
						map.game_ovr  <= 1'b1;
						map.bank_lo   <= '0;
					end
					if (ioe_wr) begin
						if (bank_cnt <= 8'd16)
							map.bank_lo <= {3'b000, data_in[3:0]};
						else if (bank_cnt <= 8'd32)
							map.bank_lo <= {2'b00, data_in[4:0]};
						else if (bank_cnt <= 8'd64)
							map.bank_lo <= {1'b0, data_in[5:0]};
						else
							map.bank_lo <= data_in[6:0];
						// Bit 7 switches the cartridge off
						map.exrom_ovr <= data_in[7];
					end
				end

				// EasyFlash, boots in Ultimax with 256 bytes of RAM at DF00
				CART_EASYFLASH: begin
					if (!init_n) begin
						map.iof_bank   <= '0;
						map.iof_ena    <= 1'b1;
						map.iof_wr_ena <= 1'b1;
						map.exrom_ovr  <= 1'b1;
						map.game_ovr   <= 1'b0;
						map.bank_lo    <= lo_bank0;
						map.bank_hi    <= hi_bank0;
					end
					if (ioe_wr) begin
						if (reg_sel) begin
							// Boot jumper assumed in boot position
							map.game_ovr  <= !data_in[0] && data_in[2];
							map.exrom_ovr <= !data_in[1];
						end else begin
							map.bank_lo <= lo_sel;
							map.bank_hi <= hi_sel;
						end
					end
				end

				// Generic 8k, 16k and Ultimax straight from the CRT header
				default: begin
					map.exrom_ovr <= cart_exrom[0];
					map.game_ovr  <= cart_game[0];
					map.bank_lo   <= lo_bank0;
					map.bank_hi   <= hi_bank0;
				end
			endcase
		end
	end

endmodule

// ==== cart_monitor.sv ====
// Cartridge output checker
`timescale 1ns/1ps

module cart_monitor (
	input  logic        clk32,
	input  logic [22:0] addr_out,
	input  logic        exrom,
	input  logic        game,
	input  logic        mem_write_out,
	input  logic        mem_ce_out,
	// Check select: addr, exrom, game, mem_write_out, mem_ce_out, cycle count
	input  logic [5:0]  chk_sel,
	input  logic [22:0] exp_addr,
	input  logic        exp_exrom,
	input  logic        exp_game,
	input  logic        exp_wr,
	input  logic        exp_ce,
	input  logic [15:0] obs_cnt,
	input  logic [15:0] exp_cnt,
	input  logic        test_done,
	input  logic [7:0]  test_num,
	output int          err_cnt,
	output int          pass_cnt,
	output int          fail_cnt
);

	int err_at_start;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			err_cnt++;
		end
	endtask

	initial begin
		err_cnt      = 0;
		pass_cnt     = 0;
		fail_cnt     = 0;
		err_at_start = 0;
	end

	// Outputs are settled half a cycle after the driving edge
	always @(negedge clk32) begin
		if (chk_sel[0])
			compare("addr_out", 32'(addr_out), 32'(exp_addr));
		if (chk_sel[1])
			compare("exrom", 32'(exrom), 32'(exp_exrom));
		if (chk_sel[2])
			compare("game", 32'(game), 32'(exp_game));
		if (chk_sel[3])
			compare("mem_write_out", 32'(mem_write_out), 32'(exp_wr));
		if (chk_sel[4])
			compare("mem_ce_out", 32'(mem_ce_out), 32'(exp_ce));
		if (chk_sel[5])
			compare("epyx_low_cycles", 32'(obs_cnt), 32'(exp_cnt));

		if (test_done) begin
			if (err_cnt == err_at_start) begin
				$display("test %0d ok", test_num);
				pass_cnt++;
			end else begin
				$display("test %0d failed", test_num);
				fail_cnt++;
			end
			err_at_start = err_cnt;
		end
	end

endmodule

// ==== cart_pkg.sv ====
// Cartridge mapper definitions

package cart_pkg;

	// **************************************************
	// CRT hardware types
	// **************************************************

	// IDs as found in the CRT header, any other ID runs as generic
	typedef enum logic [15:0] {
		CART_GENERIC    = 16'd0,
		CART_OCEAN      = 16'd5,
		CART_EPYX       = 16'd10,
		CART_MAGIC_DESK = 16'd19,
		CART_EASYFLASH  = 16'd32
	} cart_type_e;

	// **************************************************
	// Widths
	// **************************************************

	// Bank number inside the SDRAM image (128 x 8 KB)
	localparam int BANK_W = 7;

	// Bank table depth and its index width
	localparam int BANK_SLOTS = 64;
	localparam int SLOT_W     = $clog2(BANK_SLOTS);

	// SDRAM address and 8 KB page offset
	localparam int ADDR_OUT_W = 23;
	localparam int PAGE_W     = 13;

	// **************************************************
	// SDRAM layout
	// **************************************************

	// Bank prefixes at address bits 20:13
	// ROM banks start at 0x100000
	localparam logic [7:0] ROM_BASE_BANK = 8'h80;
	// RAM banks start at 0x010000, eight banks at most
	localparam logic [7:0] RAM_BASE_BANK = 8'h08;

	// Epyx capacitor discharge time in clocks
	localparam logic [15:0] EPYX_DISCHARGE = 16'd16384;

	// Register select bit inside the DE00/DF00 page
	// (EasyFlash mode register sits at DE02)
	localparam logic [7:0] IO_REG_ADDR = 8'h02;

endpackage

// ==== cartridge.sv ====
// C64 cartridge mapper top
`timescale 1ns/1ps

module cartridge
	import cart_pkg::*;
(
	input  logic                  clk32,
	input  logic                  reset_n,

	// CRT image loader
	input  logic                  cart_loading,
	input  logic [15:0]           cart_id,
	input  logic [7:0]            cart_exrom,
	input  logic [7:0]            cart_game,
	input  logic [15:0]           cart_bank_laddr,
	input  logic [15:0]           cart_bank_size,
	input  logic [15:0]           cart_bank_num,
	input  logic [22:0]           cart_bank_raddr,
	input  logic                  cart_bank_wr,

	// Expansion port lines
	output logic                  exrom,
	output logic                  game,

	// CPU side
	input  logic                  romL,
	input  logic                  romH,
	input  logic                  IOE,
	input  logic                  IOF,
	input  logic                  mem_write,
	input  logic                  mem_ce,
	output logic                  mem_ce_out,
	output logic                  mem_write_out,
	input  logic [15:0]           addr_in,
	input  logic [7:0]            data_in,
	output logic [ADDR_OUT_W-1:0] addr_out
);

	logic [BANK_W-1:0] lo_bank0;
	logic [BANK_W-1:0] hi_bank0;
	logic [BANK_W-1:0] lo_sel;
	logic [BANK_W-1:0] hi_sel;
	logic [7:0]        bank_cnt;
	logic [SLOT_W-1:0] sel_slot;

	cart_map_if map_bus ();

	cart_bank_table u_bank_table (
		.clk32           (clk32),
		.cart_loading    (cart_loading),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_raddr (cart_bank_raddr),
		.sel_slot        (sel_slot),
		.lo_bank0        (lo_bank0),
		.hi_bank0        (hi_bank0),
		.lo_sel          (lo_sel),
		.hi_sel          (hi_sel),
		.bank_cnt        (bank_cnt)
	);

	cart_mapper u_mapper (
		.clk32         (clk32),
		.reset_n       (reset_n),
		.cart_id       (cart_id),
		.cart_exrom    (cart_exrom),
		.cart_game     (cart_game),
		.cart_bank_wr  (cart_bank_wr),
		.cart_bank_num (cart_bank_num),
		.IOE           (IOE),
		.IOF           (IOF),
		.romL          (romL),
		.mem_write     (mem_write),
		.addr_in       (addr_in),
		.data_in       (data_in),
		.lo_bank0      (lo_bank0),
		.hi_bank0      (hi_bank0),
		.lo_sel        (lo_sel),
		.hi_sel        (hi_sel),
		.bank_cnt      (bank_cnt),
		.sel_slot      (sel_slot),
		.map           (map_bus.mapper)
	);

	cart_addr_xlate u_addr_xlate (
		.reset_n       (reset_n),
		.romL          (romL),
		.romH          (romH),
		.IOE           (IOE),
		.IOF           (IOF),
		.mem_write     (mem_write),
		.mem_ce        (mem_ce),
		.addr_in       (addr_in),
		.map           (map_bus.xlate),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out),
		.mem_ce_out    (mem_ce_out),
		.exrom         (exrom),
		.game          (game)
	);

endmodule

// ==== files.f ====
cart_pkg.sv
cart_map_if.sv
cart_bank_table.sv
cart_mapper.sv
cart_addr_xlate.sv
cartridge.sv
cart_asserts.sv
cart_monitor.sv
tb_cartridge.sv

// ==== tb_cartridge.sv ====
// Cartridge mapper testbench
`timescale 1ns/1ps

module tb_cartridge;

	typedef struct packed {
		logic [15:0] id;
		logic        wr;
		logic [15:0] wr_addr;
		logic [7:0]  wr_data;
		logic        romh;
		logic [6:0]  bank;
		logic        exrom;
		logic        game;
	} row_t;

	logic clk32 = 1'b0;
	logic reset_n, cart_loading, cart_bank_wr;
	logic [15:0] cart_id, cart_bank_laddr, cart_bank_size, cart_bank_num;
	logic [7:0]  cart_exrom, cart_game, data_in;
	logic [22:0] cart_bank_raddr, addr_out;
	logic exrom, game, romL, romH, IOE, IOF, mem_write, mem_ce, mem_ce_out, mem_write_out;
	logic [15:0] addr_in;

	// Checker controls
	logic [5:0]  chk_sel;
	logic [22:0] exp_addr;
	logic        exp_exrom, exp_game, exp_wr, exp_ce, test_done;
	logic [15:0] obs_cnt, exp_cnt;
	logic [7:0]  test_num;
	int          err_cnt, pass_cnt, fail_cnt, timeouts;
	logic [31:0] lfsr = 32'hb015_2633;
	row_t        rows [9];

	always #10 clk32 = ~clk32;

	cartridge u_cartridge (.*);

	cart_monitor u_monitor (.*);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic cycle(input int n = 1);
		repeat (n) @(posedge clk32);
		#2;
		chk_sel   = '0;
		test_done = 1'b0;
	endtask

	task automatic finish_test();
		test_done = 1'b1;
		test_num  = test_num + 8'd1;
		cycle();
	endtask

	task automatic select_cart(input logic [15:0] id);
		if (cart_id !== id) begin
			cart_id = id;
			cycle(4);
		end
	endtask

	task automatic load_packet(input int n, input logic [15:0] size, input logic [22:0] raddr);
		cart_bank_num   = 16'(n);
		cart_bank_laddr = 16'h8000;
		cart_bank_size  = size;
		cart_bank_raddr = raddr;
		cart_bank_wr    = 1'b1;
		cycle();
		cart_bank_wr    = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		IOE = 1'b1;
		mem_write = 1'b1;
		addr_in = a;
		data_in = d;
		cycle();
		IOE = 1'b0;
		mem_write = 1'b0;
	endtask

	initial begin
		logic [15:0] off;
		int n;
		int assert_fails;

		reset_n = 1'b1;
		{cart_loading, cart_bank_wr, romL, romH, IOE, IOF, mem_write, mem_ce} = '0;
		{cart_bank_laddr, cart_bank_size, cart_bank_num, addr_in} = '0;
		cart_bank_raddr = '0;
		cart_id = 16'd0;
		cart_exrom = 8'd0;
		cart_game = 8'd0;
		data_in = 8'd0;
		{chk_sel, exp_addr, exp_exrom, exp_game, exp_wr, exp_ce, test_done} = '0;
		{obs_cnt, exp_cnt, test_num} = '0;
		timeouts = 0;

		// Packets 0 and 1 are 16 KB with ROML in banks 0 and 2
		// Slot n from 2 upward holds bank n+2
		rows = '{
			'{16'd0,  1'b0, 16'h0000, 8'h00, 1'b0, 7'd0,  1'b0, 1'b0},
			'{16'd0,  1'b0, 16'h0000, 8'h00, 1'b1, 7'd1,  1'b0, 1'b0},
			'{16'd19, 1'b1, 16'hde00, 8'h0b, 1'b0, 7'd11, 1'b0, 1'b1},
			'{16'd19, 1'b1, 16'hde00, 8'h35, 1'b0, 7'd5,  1'b0, 1'b1},
			'{16'd19, 1'b1, 16'hde00, 8'h83, 1'b0, 7'd3,  1'b1, 1'b1},
			'{16'd32, 1'b1, 16'hde02, 8'h06, 1'b0, 7'd0,  1'b0, 1'b1},
			'{16'd32, 1'b1, 16'hde00, 8'h05, 1'b0, 7'd7,  1'b0, 1'b1},
			'{16'd5,  1'b1, 16'hde00, 8'h4c, 1'b0, 7'd12, 1'b0, 1'b0},
			'{16'd5,  1'b1, 16'hde00, 8'h21, 1'b1, 7'd33, 1'b0, 1'b0}
		};

		cycle(4);
		reset_n = 1'b0;
		cycle(2);

		// **************************************************
		// Image load of 16 packets
		// **************************************************
		cart_loading = 1'b1;
		cycle();
		for (int i = 0; i < 16; i++) begin
			if (i < 2)
				load_packet(i, 16'h4000, 23'h100000 + 23'(i) * 23'h4000);
			else
				load_packet(i, 16'h2000, 23'h100000 + 23'(i + 2) * 23'h2000);
		end
		cart_loading = 1'b0;
		cycle(2);

		// Register write then a ROML or ROMH read
		foreach (rows[i]) begin
			select_cart(rows[i].id);
			if (rows[i].wr)
				io_write(rows[i].wr_addr, rows[i].wr_data);
			take_bits(13, off);
			romL = !rows[i].romh;
			romH = rows[i].romh;
			mem_ce = 1'b1;
			addr_in = (rows[i].romh ? 16'ha000 : 16'h8000) | off;
			exp_addr = 23'h100000 + 23'(rows[i].bank) * 23'h2000 + 23'(off);
			exp_exrom = rows[i].exrom;
			exp_game = rows[i].game;
			chk_sel = 6'b000111;
			cycle();
			{romL, romH, mem_ce} = '0;
			finish_test();
		end

		// Ocean type B bank of 32 or more raises GAME
		load_packet(40, 16'h2000, 23'h150000);
		exp_game = 1'b1;
		chk_sel = 6'b000100;
		finish_test();

		// EasyFlash RAM write through IOF
		select_cart(16'd32);
		IOF = 1'b1;
		mem_write = 1'b1;
		addr_in = 16'hdf10;
		exp_addr = 23'h010000 + 23'(addr_in[12:0]);
		{exp_wr, exp_ce} = 2'b11;
		chk_sel = 6'b011001;
		cycle();
		exp_ce = 1'b0;
		chk_sel = 6'b010000;
		cycle();
		{IOF, mem_write} = '0;
		finish_test();

		// Epyx discharge after one IOE access
		select_cart(16'd10);
		IOE = 1'b1;
		addr_in = 16'hde00;
		cycle();
		IOE = 1'b0;
		n = 0;
		while (n < 20000) begin
			@(negedge clk32);
			if (exrom === 1'b1)
				break;
			n++;
		end
		if (n >= 20000) begin
			$display("Epyx exrom did not rise within 20000 cycles");
			timeouts++;
		end
		cycle();
		obs_cnt = 16'(n);
		exp_cnt = 16'd16385;
		chk_sel = 6'b100000;
		finish_test();

		// Ultimax blocks writes into ROML
		cart_exrom = 8'd1;
		select_cart(16'd0);
		romL = 1'b1;
		mem_write = 1'b1;
		mem_ce = 1'b1;
		addr_in = 16'h8123;
		exp_addr = 23'h008123;
		{exp_exrom, exp_game, exp_wr} = 3'b100;
		chk_sel = 6'b001111;
		cycle();
		{romL, mem_write, mem_ce} = '0;
		finish_test();

		cycle();
		assert_fails = u_cartridge.u_asserts.assert_errs;
		$display("tests passed %0d, failed %0d, errors %0d, timeouts %0d, asserts %0d",
			pass_cnt, fail_cnt, err_cnt, timeouts, assert_fails);
		if (err_cnt == 0 && fail_cnt == 0 && timeouts == 0 && assert_fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog for the whole run
	initial begin
		repeat (100000) @(posedge clk32);
		$display("Simulation ran out of time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
